// ==== hdl/rvv_aligner.sv ====
//####################################################################
// Lane aligner
// Packs the valid lanes of any payload into the lowest lanes, in order
//####################################################################
module rvv_aligner #(
  parameter type T   = logic [31:0],
  parameter int  NUM = 4
) (
  input  logic [NUM-1:0] valid_i,
  input  T               data_i [NUM],
  output logic [NUM-1:0] valid_o,
  output T               data_o [NUM]
);

  localparam int CNT_W = $clog2(NUM + 1);

  // Number of valid lanes strictly below each input lane
  logic [CNT_W-1:0] psum [NUM];

  always_comb begin
    psum[0] = '0;
    for (int i = 1; i < NUM; i++) begin
      psum[i] = psum[i-1] + CNT_W'(valid_i[i-1]);
    end
  end

  // Output lane o picks the valid input whose prefix count is o
  // An input only ever moves down, so the search starts at lane o
  always_comb begin
    for (int o = 0; o < NUM; o++) begin
      valid_o[o] = 1'b0;
      // Unused output lanes just carry their own input payload
      data_o[o]  = data_i[o];
      for (int i = o; i < NUM; i++) begin
        if (valid_i[i] && (psum[i] == CNT_W'(o))) begin
          valid_o[o] = 1'b1;
          data_o[o]  = data_i[i];
        end
      end
    end
  end

endmodule

// ==== hdl/rvv_cmd_if.sv ====
//####################################################################
// Command enqueue bundle between front end and command FIFO
//####################################################################
interface rvv_cmd_if;
  import rvv_core_pkg::*;

  // Aligned enqueue lanes, valid lanes are contiguous from lane 0
  logic [NUM_LANES-1:0] enq_valid;
  rvv_cmd_t             enq_data [NUM_LANES];

  // Free slots not yet claimed by the lanes in flight
  logic [CREDIT_W-1:0]  credits;

  // Front end side
  modport producer (
    output enq_valid,
    output enq_data,
    input  credits
  );

  // FIFO side
  modport consumer (
    input  enq_valid,
    input  enq_data,
    output credits
  );

endinterface

// ==== hdl/rvv_cmd_queue.sv ====
//####################################################################
// Command FIFO
// Several aligned writes per cycle, one read, free space back as credits
//####################################################################
module rvv_cmd_queue (
  input  logic                     clk,
  input  logic                     rstn,
  rvv_cmd_if.consumer              cmd,
  output logic                     cmd_valid_o,
  output rvv_core_pkg::rvv_cmd_t   cmd_data_o,
  input  logic                     cmd_ready_i
);
  import rvv_core_pkg::*;

  // Storage
  rvv_cmd_t               mem [QUEUE_DEPTH];

  logic [QUEUE_PTR_W-1:0] head_q;
  logic [QUEUE_PTR_W-1:0] tail_q;
  logic [CREDIT_W-1:0]    count_q;
  logic [LANE_CNT_W-1:0]  enq_cnt;
  logic                   deq;

  // Lanes arrive packed, so a plain count gives the used lanes
  always_comb begin
    enq_cnt = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      enq_cnt = enq_cnt + LANE_CNT_W'(cmd.enq_valid[i]);
    end
  end

  assign cmd_valid_o = (count_q != '0);
  assign cmd_data_o  = mem[head_q];
  assign deq         = cmd_valid_o && cmd_ready_i;

  // Lanes in flight are already counted against the free space
  // A dequeue shows up one cycle later through count_q
  assign cmd.credits = CREDIT_W'(QUEUE_DEPTH) - count_q - CREDIT_W'(enq_cnt);

  // Lane i goes to tail plus i, wrap is implicit in the pointer width
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      if (cmd.enq_valid[i]) begin
        mem[tail_q + QUEUE_PTR_W'(i)] <= cmd.enq_data[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      tail_q  <= tail_q + QUEUE_PTR_W'(enq_cnt);
      head_q  <= head_q + QUEUE_PTR_W'(deq);
      // Writes never overrun since the front end spends only credits
      count_q <= count_q + CREDIT_W'(enq_cnt) - CREDIT_W'(deq);
    end
  end

endmodule

// ==== hdl/rvv_core_pkg.sv ====
//####################################################################
// RVV core package
// Front end sizing, architectural configuration state and command record
//####################################################################
package rvv_core_pkg;

  // Instructions offered per cycle by the dispatcher
  localparam int NUM_LANES = 4;

  // Command FIFO entries
  localparam int QUEUE_DEPTH = 16;

  // Credit count must hold 0 up to QUEUE_DEPTH
  localparam int CREDIT_W = $clog2(QUEUE_DEPTH + 1);

  // One rs1 port and one rs2 port per lane
  // rs1 of lane i is port 2*i, rs2 is port 2*i+1
  localparam int RF_READ_PORTS = 2 * NUM_LANES;

  // Width of a count of 0 up to NUM_LANES lanes
  localparam int LANE_CNT_W = $clog2(NUM_LANES + 1);

  // FIFO pointer width, depth is a power of two so pointers wrap freely
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

  // vl out of reset
  localparam logic [31:0] CONFIG_RESET_VL = 32'd16;

  // Architectural vector configuration state
  typedef struct packed {
    logic [31:0]                      vl;
    rvv_isa_pkg::rvv_lmul_e           lmul;
    rvv_isa_pkg::rvv_sew_e            sew;
    logic                             ta;
    logic                             ma;
    logic [rvv_isa_pkg::VSTART_W-1:0] vstart;
    rvv_isa_pkg::rvv_xrm_e            xrm;
  } rvv_config_t;

  // Instruction combined with the state it executes under
  typedef struct packed {
    rvv_isa_pkg::rvv_opcode_e opcode;
    logic [24:0]              bits;
    rvv_config_t              arch_state;
    logic [31:0]              rs1;
  } rvv_cmd_t;

endpackage

// ==== hdl/rvv_frontend.sv ====
//####################################################################
// RVV front end
// Accepts instructions under credit, runs vset* and builds FIFO commands
//####################################################################
module rvv_frontend (
  input  logic                                                clk,
  input  logic                                                rstn,
  input  logic [rvv_isa_pkg::VSTART_W-1:0]                    vstart_i,
  input  rvv_isa_pkg::rvv_xrm_e                               vxrm_i,
  // Dispatch lanes, any lane may be empty
  input  logic [rvv_core_pkg::NUM_LANES-1:0]                  inst_valid_i,
  input  rvv_isa_pkg::rvv_inst_t [rvv_core_pkg::NUM_LANES-1:0] inst_data_i,
  output logic [rvv_core_pkg::NUM_LANES-1:0]                  inst_ready_o,
  // Scalar operands, one cycle after acceptance
  input  logic [rvv_core_pkg::RF_READ_PORTS-1:0]              reg_read_valid_i,
  input  logic [rvv_core_pkg::RF_READ_PORTS-1:0][31:0]        reg_read_data_i,
  // New vl written back to rd of vset*
  output logic [rvv_core_pkg::NUM_LANES-1:0]                  reg_write_valid_o,
  output logic [rvv_core_pkg::NUM_LANES-1:0][4:0]             reg_write_addr_o,
  output logic [rvv_core_pkg::NUM_LANES-1:0][31:0]            reg_write_data_o,
  output logic                                                config_valid_o,
  output rvv_core_pkg::rvv_config_t                           config_state_o,
  rvv_cmd_if.producer                                         cmd
);
  import rvv_isa_pkg::*;
  import rvv_core_pkg::*;

  logic [LANE_CNT_W-1:0] in_psum [NUM_LANES];
  logic [NUM_LANES-1:0]  inst_accept;

  // Stage holding the accepted lanes
  logic [NUM_LANES-1:0]  inst_valid_q;
  rvv_inst_t [NUM_LANES-1:0] inst_q;

  // State before lane i is chain[i], after the last lane chain[NUM_LANES]
  rvv_config_t           config_q;
  rvv_config_t           chain [NUM_LANES+1];
  logic [NUM_LANES-1:0]  is_cfg;

  // Commands before packing
  logic [NUM_LANES-1:0]  cmd_valid_raw;
  rvv_cmd_t              cmd_data_raw [NUM_LANES];

  // Count of offered lanes below each lane
  always_comb begin
    in_psum[0] = '0;
    for (int i = 1; i < NUM_LANES; i++) begin
      in_psum[i] = in_psum[i-1] + LANE_CNT_W'(inst_valid_i[i-1]);
    end
  end

  // Lane gets in while the lanes below it still leave a credit
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      inst_accept[i] = inst_valid_i[i] && (CREDIT_W'(in_psum[i]) < cmd.credits);
    end
  end

  assign inst_ready_o = inst_accept;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      inst_valid_q <= '0;
    end else begin
      inst_valid_q <= inst_accept;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      if (inst_accept[i]) begin
        inst_q[i] <= inst_data_i[i];
      end
    end
  end

  // Fold vset* lane by lane into the state
  // zimm bits[20:13] has the same layout as vtype[7:0]
  always_comb begin
    logic [7:0] vtype;
    logic       imm_vl;
    logic       reg_vtype;
    chain[0]        = config_q;
    chain[0].vstart = vstart_i;
    chain[0].xrm    = vxrm_i;
    for (int i = 0; i < NUM_LANES; i++) begin
      chain[i+1] = chain[i];
      is_cfg[i]  = inst_valid_q[i] && (inst_q[i].opcode == OPC_RVV) &&
                   (inst_q[i].bits[7:5] == FUNCT3_OPCFG);
      // vsetivli when bits[24:23] is 11, vsetvl when 10, else vsetvli
      imm_vl    = inst_q[i].bits[24] && inst_q[i].bits[23];
      reg_vtype = inst_q[i].bits[24] && !inst_q[i].bits[23];
      vtype     = reg_vtype ? reg_read_data_i[2*i+1][7:0] : inst_q[i].bits[20:13];
      if (is_cfg[i]) begin
        chain[i+1].vl   = imm_vl ? 32'(inst_q[i].bits[12:8]) : reg_read_data_i[2*i];
        chain[i+1].lmul = rvv_lmul_e'(vtype[2:0]);
        chain[i+1].sew  = rvv_sew_e'(vtype[5:3]);
        chain[i+1].ta   = vtype[6];
        chain[i+1].ma   = vtype[7];
      end
    end
  end

  // Other lanes become commands under the state at their position
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      cmd_valid_raw[i]              = inst_valid_q[i] && !is_cfg[i];
      cmd_data_raw[i].opcode        = inst_q[i].opcode;
      cmd_data_raw[i].bits          = inst_q[i].bits;
      cmd_data_raw[i].arch_state    = chain[i];
      // Scalar rs1 only for the .vx style forms
      cmd_data_raw[i].rs1           = (inst_q[i].bits[7] && reg_read_valid_i[2*i]) ?
                                      reg_read_data_i[2*i] : '0;
      reg_write_valid_o[i]          = is_cfg[i];
      reg_write_addr_o[i]           = inst_q[i].bits[4:0];
      reg_write_data_o[i]           = chain[i+1].vl;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      config_q.vl     <= CONFIG_RESET_VL;
      config_q.lmul   <= LMUL1;
      config_q.sew    <= SEW8;
      config_q.ta     <= 1'b0;
      config_q.ma     <= 1'b0;
      config_q.vstart <= '0;
      config_q.xrm    <= RNU;
    end else begin
      config_q <= chain[NUM_LANES];
    end
  end

  // State is only settled when nothing sits in the stage
  assign config_valid_o = ~|inst_valid_q;
  assign config_state_o = config_q;

  // Pack commands into the lowest enqueue lanes
  rvv_aligner #(
    .T   (rvv_cmd_t),
    .NUM (NUM_LANES)
  ) u_cmd_aligner (
    .valid_i (cmd_valid_raw),
    .data_i  (cmd_data_raw),
    .valid_o (cmd.enq_valid),
    .data_o  (cmd.enq_data)
  );

endmodule

// ==== hdl/rvv_frontend_top.sv ====
//####################################################################
// RVV front end top
// Front end and command FIFO behind plain ports
//####################################################################
module rvv_frontend_top (
  input  logic                                                clk,
  input  logic                                                rstn,
  input  logic [rvv_isa_pkg::VSTART_W-1:0]                    vstart_i,
  input  rvv_isa_pkg::rvv_xrm_e                               vxrm_i,
  // Dispatch side
  input  logic [rvv_core_pkg::NUM_LANES-1:0]                  inst_valid_i,
  input  rvv_isa_pkg::rvv_inst_t [rvv_core_pkg::NUM_LANES-1:0] inst_data_i,
  output logic [rvv_core_pkg::NUM_LANES-1:0]                  inst_ready_o,
  // Scalar register file
  input  logic [rvv_core_pkg::RF_READ_PORTS-1:0]              reg_read_valid_i,
  input  logic [rvv_core_pkg::RF_READ_PORTS-1:0][31:0]        reg_read_data_i,
  output logic [rvv_core_pkg::NUM_LANES-1:0]                  reg_write_valid_o,
  output logic [rvv_core_pkg::NUM_LANES-1:0][4:0]             reg_write_addr_o,
  output logic [rvv_core_pkg::NUM_LANES-1:0][31:0]            reg_write_data_o,
  // Configuration state
  output logic                                                config_valid_o,
  output rvv_core_pkg::rvv_config_t                           config_state_o,
  // Command stream to the vector back end
  output logic                                                cmd_valid_o,
  output rvv_core_pkg::rvv_cmd_t                              cmd_data_o,
  input  logic                                                cmd_ready_i
);

  // Enqueue lanes and credits between the two blocks
  rvv_cmd_if cmd_if ();

  rvv_frontend u_frontend (
    .clk               (clk),
    .rstn              (rstn),
    .vstart_i          (vstart_i),
    .vxrm_i            (vxrm_i),
    .inst_valid_i      (inst_valid_i),
    .inst_data_i       (inst_data_i),
    .inst_ready_o      (inst_ready_o),
    .reg_read_valid_i  (reg_read_valid_i),
    .reg_read_data_i   (reg_read_data_i),
    .reg_write_valid_o (reg_write_valid_o),
    .reg_write_addr_o  (reg_write_addr_o),
    .reg_write_data_o  (reg_write_data_o),
    .config_valid_o    (config_valid_o),
    .config_state_o    (config_state_o),
    .cmd               (cmd_if)
  );

  rvv_cmd_queue u_cmd_queue (
    .clk         (clk),
    .rstn        (rstn),
    .cmd         (cmd_if),
    .cmd_valid_o (cmd_valid_o),
    .cmd_data_o  (cmd_data_o),
    .cmd_ready_i (cmd_ready_i)
  );

endmodule

// ==== hdl/rvv_isa_pkg.sv ====
//####################################################################
// RVV ISA package
// Encoding types of the vector instructions offered by the dispatcher
//####################################################################
package rvv_isa_pkg;

  // Width of the vstart CSR
  localparam int VSTART_W = 7;

  // funct3 value of the vset* group
  // Sits in bits[7:5] of the record (instruction bits 14:12)
  localparam logic [2:0] FUNCT3_OPCFG = 3'b111;

  // Major opcode class of an offered instruction
  typedef enum logic [1:0] {
    OPC_LOAD  = 2'b00,
    OPC_STORE = 2'b01,
    OPC_RVV   = 2'b10
  } rvv_opcode_e;

  // vlmul encoding as in the vtype CSR
  typedef enum logic [2:0] {
    LMUL1   = 3'b000,
    LMUL2   = 3'b001,
    LMUL4   = 3'b010,
    LMUL8   = 3'b011,
    LMUL1_8 = 3'b101,
    LMUL1_4 = 3'b110,
    LMUL1_2 = 3'b111
  } rvv_lmul_e;

  // vsew encoding, only up to 32 bit elements
  typedef enum logic [2:0] {
    SEW8  = 3'b000,
    SEW16 = 3'b001,
    SEW32 = 3'b010
  } rvv_sew_e;

  // Fixed-point rounding mode (vxrm)
  typedef enum logic [1:0] {
    RNU = 2'b00,
    RNE = 2'b01,
    RDN = 2'b10,
    ROD = 2'b11
  } rvv_xrm_e;

  // One instruction as handed over by the scalar side
  // bits holds instruction bits 31:7, so bits[4:0] is rd,
  // bits[7:5] is funct3 and bits[24] is instruction bit 31
  typedef struct packed {
    rvv_opcode_e opcode;
    logic [24:0] bits;
  } rvv_inst_t;

endpackage

// ==== sources.f ====
hdl/rvv_isa_pkg.sv
hdl/rvv_core_pkg.sv
hdl/rvv_cmd_if.sv
hdl/rvv_aligner.sv
hdl/rvv_frontend.sv
hdl/rvv_cmd_queue.sv
hdl/rvv_frontend_top.sv
tb/rvv_frontend_sva.sv
tb/tb_rvv_frontend.sv

// ==== tb/rvv_frontend_sva.sv ====
//######################################################################
// Front end assertions on operand availability and FIFO credit safety
//######################################################################
module rvv_frontend_sva (
  input logic                                                 clk,
  input logic                                                 rstn,
  input logic [rvv_core_pkg::NUM_LANES-1:0]                   stage_valid_i,
  input rvv_isa_pkg::rvv_inst_t [rvv_core_pkg::NUM_LANES-1:0] stage_inst_i,
  input logic [rvv_core_pkg::NUM_LANES-1:0]                   cfg_lane_i,
  input logic [rvv_core_pkg::RF_READ_PORTS-1:0]               reg_read_valid_i,
  input logic [rvv_core_pkg::CREDIT_W-1:0]                    credits_i
);
  timeunit 1ns;
  timeprecision 1ps;
  import rvv_core_pkg::*;

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    // rs1 feeds vsetvli, vsetvl and the scalar operand forms
    a_rs1_valid: assert property (@(posedge clk) disable iff (!rstn)
      stage_valid_i[i] && stage_inst_i[i].bits[7] |-> reg_read_valid_i[2*i])
      else $error("lane %0d staged without its rs1 operand", i);
    // vsetvl takes its vtype from rs2
    a_rs2_valid: assert property (@(posedge clk) disable iff (!rstn)
      cfg_lane_i[i] && stage_inst_i[i].bits[24] && !stage_inst_i[i].bits[23]
      |-> reg_read_valid_i[2*i+1])
      else $error("lane %0d vsetvl staged without its rs2 operand", i);
  end

  // Occupancy plus lanes in flight past the depth wraps the credit count
  a_credit: assert property (@(posedge clk) disable iff (!rstn)
    credits_i <= CREDIT_W'(QUEUE_DEPTH))
    else $error("FIFO written beyond its depth");

endmodule

bind rvv_frontend rvv_frontend_sva sva0 (
  .clk              (clk),
  .rstn             (rstn),
  .stage_valid_i    (inst_valid_q),
  .stage_inst_i     (inst_q),
  .cfg_lane_i       (is_cfg),
  .reg_read_valid_i (reg_read_valid_i),
  .credits_i        (cmd.credits)
);

// ==== tb/tb_rvv_frontend.sv ====
//######################################################################
// Testbench for the RVV front end top
// Directed tests against a model of the vset* state and command order
//######################################################################
module tb_rvv_frontend;
  timeunit 1ns;
  timeprecision 1ps;
  import rvv_isa_pkg::*;
  import rvv_core_pkg::*;

  typedef rvv_inst_t [NUM_LANES-1:0] inst_lanes_t;

  // All tests together need a few hundred cycles
  localparam int MAX_CYCLES = 4000;
  localparam logic [VSTART_W-1:0] VSTART_VAL = 7'd5;
  localparam rvv_xrm_e XRM_VAL = RDN;

  logic clk = 1'b0;
  logic rstn;
  logic [VSTART_W-1:0] vstart_i;
  rvv_xrm_e vxrm_i;
  logic [NUM_LANES-1:0] inst_valid_i;
  inst_lanes_t inst_data_i;
  logic [NUM_LANES-1:0] inst_ready_o;
  logic [RF_READ_PORTS-1:0] reg_read_valid_i;
  logic [RF_READ_PORTS-1:0][31:0] reg_read_data_i;
  logic [NUM_LANES-1:0] reg_write_valid_o;
  logic [NUM_LANES-1:0][4:0] reg_write_addr_o;
  logic [NUM_LANES-1:0][31:0] reg_write_data_o;
  logic config_valid_o;
  rvv_config_t config_state_o;
  logic cmd_valid_o;
  rvv_cmd_t cmd_data_o;
  logic cmd_ready_i;

  // Scalar register values per read port, rs1 of lane i at 2*i
  logic [RF_READ_PORTS-1:0][31:0] rf_tab;
  // Model of the stage, the state register and the FIFO contents
  logic [NUM_LANES-1:0] staged_valid;
  inst_lanes_t staged_inst;
  rvv_config_t m_cfg;
  rvv_cmd_t exp_q [$];
  int errors = 0;
  int ntests = 0;
  int cycles = 0;

  rvv_frontend_top dut0 (.*);

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout, run stopped after %0d cycles", cycles);
      $display("tests failed");
      $finish;
    end
  end

  function automatic rvv_config_t reset_cfg();
    return '{vl: 32'd16, lmul: LMUL1, sew: SEW8, ta: 1'b0, ma: 1'b0, vstart: '0, xrm: RNU};
  endfunction

  // Encoders, bits holds instruction bits 31:7
  function automatic rvv_inst_t enc_vsetvli(logic [4:0] rd, logic [4:0] rs1, logic [7:0] vt);
    return '{opcode: OPC_RVV, bits: {1'b0, 3'b000, vt, rs1, 3'b111, rd}};
  endfunction

  function automatic rvv_inst_t enc_vsetivli(logic [4:0] rd, logic [4:0] uimm, logic [7:0] vt);
    return '{opcode: OPC_RVV, bits: {2'b11, 2'b00, vt, uimm, 3'b111, rd}};
  endfunction

  function automatic rvv_inst_t enc_vsetvl(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return '{opcode: OPC_RVV, bits: {7'b1000000, rs2, rs1, 3'b111, rd}};
  endfunction

  // Arithmetic with any funct3 but the vset* one
  function automatic rvv_inst_t rand_arith();
    rvv_inst_t r;
    r.opcode = OPC_RVV;
    r.bits = 25'($urandom);
    r.bits[7:5] = 3'($urandom_range(6, 0));
    return r;
  endfunction

  task automatic check_cmd(input rvv_cmd_t got, input rvv_cmd_t exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: command %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_config(input rvv_config_t got, input rvv_config_t exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: config state %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_reg_write(input logic [4:0] got_addr, input logic [31:0] got_data,
                                 input logic [4:0] exp_addr, input logic [31:0] exp_data);
    if (got_addr !== exp_addr || got_data !== exp_data) begin
      errors++;
      $display("** Error at %0t: vl write x%0d=%0d, expected x%0d=%0d", $time,
               got_addr, got_data, exp_addr, exp_data);
    end
  endtask

  task automatic check_mask(input string what, input logic [NUM_LANES-1:0] got,
                            input logic [NUM_LANES-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Checks one cycle at the falling edge and advances the model
  task automatic sample();
    rvv_config_t cur;
    rvv_inst_t in;
    logic [NUM_LANES-1:0] exp_wr;
    logic [NUM_LANES-1:0] exp_acc;
    logic [31:0] vl;
    logic [7:0] vt;
    logic pop;
    int below;
    check_mask("config_valid_o", NUM_LANES'(config_valid_o), NUM_LANES'(staged_valid == '0));
    check_config(config_state_o, m_cfg);
    check_mask("cmd_valid_o", NUM_LANES'(cmd_valid_o), NUM_LANES'(exp_q.size() != 0));
    pop = cmd_valid_o && cmd_ready_i && (exp_q.size() != 0);
    if (pop) begin
      check_cmd(cmd_data_o, exp_q[0]);
    end
    // vstart and vxrm enter the state every cycle
    cur = m_cfg;
    cur.vstart = vstart_i;
    cur.xrm = vxrm_i;
    exp_wr = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      in = staged_inst[i];
      if (staged_valid[i] && in.opcode == OPC_RVV && in.bits[7:5] == 3'b111) begin
        // Bit 31 clear is vsetvli, bits 31:30 set is vsetivli, else vsetvl
        vl = rf_tab[2*i];
        vt = in.bits[20:13];
        if (in.bits[24] && in.bits[23]) begin
          vl = {27'd0, in.bits[12:8]};
        end else if (in.bits[24]) begin
          vt = rf_tab[2*i+1][7:0];
        end
        cur.vl = vl;
        cur.lmul = rvv_lmul_e'(vt[2:0]);
        cur.sew = rvv_sew_e'(vt[5:3]);
        cur.ta = vt[6];
        cur.ma = vt[7];
        exp_wr[i] = 1'b1;
        check_reg_write(reg_write_addr_o[i], reg_write_data_o[i], in.bits[4:0], vl);
      end else if (staged_valid[i]) begin
        exp_q.push_back(rvv_cmd_t'{opcode: in.opcode, bits: in.bits, arch_state: cur,
                                   rs1: in.bits[7] ? rf_tab[2*i] : 32'd0});
      end
    end
    check_mask("reg_write_valid_o", reg_write_valid_o, exp_wr);
    m_cfg = cur;
    // Free slots are those not held by queued or staged commands
    below = 0;
    for (int i = 0; i < NUM_LANES; i++) begin
      exp_acc[i] = inst_valid_i[i] && (below < QUEUE_DEPTH - exp_q.size());
      below += int'(inst_valid_i[i]);
    end
    check_mask("inst_ready_o", inst_ready_o, exp_acc);
    if (pop) begin
      void'(exp_q.pop_front());
    end
    staged_valid = exp_acc;
    staged_inst = inst_data_i;
  endtask

  task automatic step(input logic [NUM_LANES-1:0] v, input inst_lanes_t d, input logic ready);
    @(posedge clk);
    #10;
    inst_valid_i = v;
    inst_data_i = d;
    cmd_ready_i = ready;
    // Register file answers for the lanes accepted one cycle ago
    for (int i = 0; i < NUM_LANES; i++) begin
      reg_read_valid_i[2*i] = staged_valid[i];
      reg_read_valid_i[2*i+1] = staged_valid[i];
    end
    reg_read_data_i = rf_tab;
    @(negedge clk);
    sample();
  endtask

  task automatic drain();
    do begin
      step('0, '0, 1'b1);
    end while (exp_q.size() != 0 || staged_valid != '0);
  endtask

  task automatic report(input string name, input int err_start);
    ntests++;
    $display("test %s finished with %0d errors", name, errors - err_start);
  endtask

  task automatic test_reset();
    int e0 = errors;
    inst_lanes_t d = '0;
    @(negedge clk);
    check_mask("config_valid_o", NUM_LANES'(config_valid_o), NUM_LANES'(1));
    check_config(config_state_o, reset_cfg());
    sample();
    // First command carries the reset vl, SEW and LMUL
    d[2] = rand_arith();
    step(4'b0100, d, 1'b1);
    drain();
    report("reset", e0);
  endtask

  task automatic test_packing();
    int e0 = errors;
    inst_lanes_t d;
    for (int i = 0; i < RF_READ_PORTS; i++) begin
      rf_tab[i] = $urandom;
    end
    for (int n = 0; n < 12; n++) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        d[i] = rand_arith();
      end
      step(NUM_LANES'($urandom), d, 1'b1);
    end
    drain();
    report("packing", e0);
  endtask

  task automatic test_vsetivli();
    int e0 = errors;
    inst_lanes_t d = '0;
    // vl 9, ta set, SEW16, LMUL2
    d[0] = enc_vsetivli(5'd5, 5'd9, 8'b0100_1001);
    d[1] = rand_arith();
    d[3] = rand_arith();
    step(4'b1011, d, 1'b1);
    drain();
    check_config(config_state_o, '{vl: 32'd9, lmul: LMUL2, sew: SEW16, ta: 1'b1, ma: 1'b0,
                                   vstart: VSTART_VAL, xrm: XRM_VAL});
    report("vsetivli", e0);
  endtask

  task automatic test_vsetvl();
    int e0 = errors;
    inst_lanes_t d;
    rf_tab[0] = 32'd37;
    rf_tab[2] = 32'h1234_5678;
    rf_tab[4] = 32'd100;
    // vtype from rs2 with ta set, SEW32, LMUL8
    rf_tab[5] = 32'h0000_0053;
    // ma set, SEW32, LMUL 1/2
    d[0] = enc_vsetvli(5'd1, 5'd10, 8'b1001_0111);
    // OPIVX form, takes the scalar rs1
    d[1] = rand_arith();
    d[1].bits[7:5] = 3'b100;
    d[2] = enc_vsetvl(5'd3, 5'd11, 5'd12);
    d[3] = rand_arith();
    step(4'b1111, d, 1'b1);
    drain();
    check_config(config_state_o, '{vl: 32'd100, lmul: LMUL8, sew: SEW32, ta: 1'b1, ma: 1'b0,
                                   vstart: VSTART_VAL, xrm: XRM_VAL});
    report("vsetvl", e0);
  endtask

  task automatic test_backpressure();
    int e0 = errors;
    int held = 0;
    inst_lanes_t d;
    do begin
      for (int i = 0; i < NUM_LANES; i++) begin
        d[i] = rand_arith();
      end
      step(4'b1111, d, 1'b0);
    end while (staged_valid != '0);
    // Count the commands the DUT hands out until it runs dry
    do begin
      step('0, '0, 1'b1);
      held += int'(cmd_valid_o);
    end while (exp_q.size() != 0 || staged_valid != '0 || cmd_valid_o);
    if (held != QUEUE_DEPTH) begin
      errors++;
      $display("** Error at %0t: %0d commands held, expected %0d", $time, held,
               QUEUE_DEPTH);
    end
    report("backpressure", e0);
  endtask

  initial begin
    void'($urandom(21060));
    rstn = 1'b0;
    vstart_i = VSTART_VAL;
    vxrm_i = XRM_VAL;
    inst_valid_i = '0;
    inst_data_i = '0;
    reg_read_valid_i = '0;
    reg_read_data_i = '0;
    cmd_ready_i = 1'b0;
    rf_tab = '0;
    staged_valid = '0;
    staged_inst = '0;
    m_cfg = reset_cfg();
    repeat (4) @(posedge clk);
    #10;
    rstn = 1'b1;
    test_reset();
    test_packing();
    test_vsetivli();
    test_vsetvl();
    test_backpressure();
    $display("%0d tests run, %0d errors", ntests, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
